// ==== sbox_settings.svh ====
// share count, layer widths, gate count, randomness width and stage count
`ifndef SBOX_SETTINGS_SVH
`define SBOX_SETTINGS_SVH

// boolean shares per masked bit
`define SBOX_SHARES 3

// per-share widths around the nonlinear core
`define SBOX_TOP_BITS 21
`define SBOX_MID_BITS 18

// masked AND gates in the middle layer and fresh bits each one needs
`define SBOX_AND_GATES 34
`define SBOX_RAND_PER_AND (`SBOX_SHARES * (`SBOX_SHARES - 1) / 2)
`define SBOX_RAND_BITS (`SBOX_AND_GATES * `SBOX_RAND_PER_AND)

// pipeline depth of the middle layer
`define SBOX_STAGES 4

`endif

// ==== sbox_pkg.sv ====
// direction opcode, share vector types and request/response structs
`include "sbox_settings.svh"

package sbox_pkg;

    // forward or inverse S-box
    typedef enum logic {
        SBOX_ENC = 1'b0,
        SBOX_DEC = 1'b1
    } sbox_dir_t;

    // one byte per share, share 0 in the low byte
    typedef logic [`SBOX_SHARES-1:0][7:0] masked_byte_t;

    // expanded vector after the input layer
    typedef logic [`SBOX_SHARES-1:0][`SBOX_TOP_BITS-1:0] top_vec_t;

    // compressed vector ahead of the output layer
    typedef logic [`SBOX_SHARES-1:0][`SBOX_MID_BITS-1:0] mid_vec_t;

    // all shares of a single bit, the unit of a masked gate
    typedef logic [`SBOX_SHARES-1:0] share_bit_t;

    typedef struct packed {
        sbox_dir_t    dir;
        masked_byte_t data;
    } sbox_req_t;

    typedef struct packed {
        masked_byte_t data;
    } sbox_rsp_t;

endpackage

// ==== dom_and.sv ====
// registered domain-oriented masked AND gate over all shares
`timescale 1ns/1ns

module dom_and #(
    parameter int SHARES = $bits(sbox_pkg::share_bit_t)
) (
    input  logic                           g_clk,
    input  logic                           advance,
    input  logic [SHARES*(SHARES-1)/2-1:0] rng,
    input  sbox_pkg::share_bit_t           a,
    input  sbox_pkg::share_bit_t           b,
    output sbox_pkg::share_bit_t           y
);

    // row i holds every product that ends up in domain i
    logic [SHARES-1:0][SHARES-1:0] prod_d;
    logic [SHARES-1:0][SHARES-1:0] prod_q;

    for (genvar i = 0; i < SHARES; i++) begin : g_row
        for (genvar j = 0; j < SHARES; j++) begin : g_col
            if (i == j) begin : g_inner
                assign prod_d[i][j] = a[i] & b[j];
            end else begin : g_cross
                // both halves of a domain pair share one fresh bit
                localparam int LO = (i < j) ? i : j;
                localparam int HI = (i < j) ? j : i;
                localparam int R  = LO * SHARES - LO * (LO + 1) / 2 + HI - LO - 1;
                assign prod_d[i][j] = (a[i] & b[j]) ^ rng[R];
            end
        end
        // compression after the register keeps glitches from combining domains
        assign y[i] = ^prod_q[i];
    end

    always_ff @(posedge g_clk) begin
        if (advance) begin
            prod_q <= prod_d;
        end
    end

endmodule

// ==== sbox_in_layer.sv ====
// forward and inverse 8-to-21 linear input layers with direction select
`timescale 1ns/1ns
`include "sbox_settings.svh"

module sbox_in_layer (
    input  sbox_pkg::sbox_dir_t    dir,
    input  sbox_pkg::masked_byte_t x,
    output sbox_pkg::top_vec_t     y
);

    // forward AES top layer, one share
    function automatic logic [`SBOX_TOP_BITS-1:0] fwd_top(input logic [7:0] b);
        logic [5:0]                t;
        logic [`SBOX_TOP_BITS-1:0] v;
        v[0]  = b[0];
        v[1]  = b[7] ^ b[4];
        v[2]  = b[7] ^ b[2];
        v[3]  = b[7] ^ b[1];
        v[4]  = b[4] ^ b[2];
        t[0]  = b[3] ^ b[1];
        v[5]  = v[1] ^ t[0];
        t[1]  = b[6] ^ b[5];
        v[6]  = b[0] ^ v[5];
        v[7]  = b[0] ^ t[1];
        v[8]  = v[5] ^ t[1];
        t[2]  = b[6] ^ b[2];
        t[3]  = b[5] ^ b[2];
        v[9]  = v[3] ^ v[4];
        v[10] = v[5] ^ t[2];
        v[11] = t[0] ^ t[2];
        v[12] = t[0] ^ t[3];
        v[13] = v[7] ^ v[12];
        t[4]  = b[4] ^ b[0];
        v[14] = t[1] ^ t[4];
        v[15] = v[1] ^ v[14];
        t[5]  = b[1] ^ b[0];
        v[16] = t[1] ^ t[5];
        v[17] = v[2] ^ v[16];
        v[18] = v[2] ^ v[8];
        v[19] = v[15] ^ v[13];
        v[20] = v[1] ^ t[3];
        return v;
    endfunction

    // inverse top layer, c flips the complemented terms on one share only
    function automatic logic [`SBOX_TOP_BITS-1:0] inv_top(input logic [7:0] b, input logic c);
        logic [4:0]                t;
        logic [`SBOX_TOP_BITS-1:0] v;
        v[17] = b[7] ^ b[4];
        v[16] = b[6] ^ b[4] ^ c;
        v[2]  = b[7] ^ b[6] ^ c;
        v[1]  = b[4] ^ b[3];
        v[18] = b[3] ^ b[0] ^ c;
        t[0]  = b[1] ^ b[0];
        v[6]  = b[6] ^ v[17] ^ c;
        v[14] = v[16] ^ t[0];
        v[7]  = b[0] ^ v[1] ^ c;
        v[8]  = v[2] ^ v[18];
        v[9]  = v[2] ^ t[0];
        v[3]  = v[1] ^ t[0];
        v[19] = b[5] ^ v[1] ^ c;
        t[1]  = b[6] ^ b[1];
        v[13] = b[5] ^ v[14] ^ c;
        v[15] = v[18] ^ t[1];
        v[4]  = b[3] ^ v[6];
        t[2]  = b[5] ^ b[2] ^ c;
        t[3]  = b[2] ^ b[1] ^ c;
        t[4]  = b[5] ^ b[3] ^ c;
        v[5]  = v[16] ^ t[2];
        v[12] = t[1] ^ t[4];
        v[20] = v[1] ^ t[3];
        v[11] = v[8] ^ v[20];
        v[10] = v[8] ^ t[3];
        v[0]  = b[7] ^ t[2];
        return v;
    endfunction

    // linear, so each share goes through on its own
    for (genvar s = 0; s < `SBOX_SHARES; s++) begin : g_share
        assign y[s] = (dir == sbox_pkg::SBOX_DEC) ? inv_top(x[s], s == 0) : fwd_top(x[s]);
    end

endmodule

// ==== sbox_out_layer.sv ====
// forward and inverse 18-to-8 linear output layers with direction select
`timescale 1ns/1ns
`include "sbox_settings.svh"

module sbox_out_layer (
    input  sbox_pkg::sbox_dir_t    dir,
    input  sbox_pkg::mid_vec_t     x,
    output sbox_pkg::masked_byte_t y
);

    // forward bottom layer, c adds the affine constant 0x63
    function automatic logic [7:0] fwd_out(input logic [`SBOX_MID_BITS-1:0] v, input logic c);
        logic [29:0] t;
        logic [7:0]  o;
        t[0]  = v[11] ^ v[12];
        t[1]  = v[0] ^ v[6];
        t[2]  = v[14] ^ v[16];
        t[3]  = v[15] ^ v[5];
        t[4]  = v[4] ^ v[8];
        t[5]  = v[17] ^ v[11];
        t[6]  = v[12] ^ t[5];
        t[7]  = v[14] ^ t[3];
        t[8]  = v[1] ^ v[9];
        t[9]  = v[2] ^ v[3];
        t[10] = v[3] ^ t[4];
        t[11] = v[10] ^ t[2];
        t[12] = v[16] ^ v[1];
        t[13] = v[0] ^ t[0];
        t[14] = v[2] ^ v[11];
        t[15] = v[5] ^ t[1];
        t[16] = v[6] ^ t[0];
        t[17] = v[7] ^ t[1];
        t[18] = v[8] ^ t[8];
        t[19] = v[13] ^ t[4];
        t[20] = t[0] ^ t[1];
        t[21] = t[1] ^ t[7];
        t[22] = t[3] ^ t[12];
        t[23] = t[18] ^ t[2];
        t[24] = t[15] ^ t[9];
        t[25] = t[6] ^ t[10];
        t[26] = t[7] ^ t[9];
        t[27] = t[8] ^ t[10];
        t[28] = t[11] ^ t[14];
        t[29] = t[11] ^ t[17];
        o[0]  = t[6] ^ t[23] ^ c;
        o[1]  = t[13] ^ t[27] ^ c;
        o[2]  = t[25] ^ t[29];
        o[3]  = t[20] ^ t[22];
        o[4]  = t[6] ^ t[21];
        o[5]  = t[19] ^ t[28] ^ c;
        o[6]  = t[16] ^ t[26] ^ c;
        o[7]  = t[6] ^ t[24];
        return o;
    endfunction

    // inverse bottom layer, purely linear
    function automatic logic [7:0] inv_out(input logic [`SBOX_MID_BITS-1:0] v);
        logic [29:0] t;
        logic [7:0]  o;
        t     = '0;
        t[0]  = v[2] ^ v[11];
        t[1]  = v[8] ^ v[9];
        t[2]  = v[4] ^ v[12];
        t[3]  = v[15] ^ v[0];
        t[4]  = v[16] ^ v[6];
        t[5]  = v[14] ^ v[1];
        t[6]  = v[17] ^ v[10];
        t[7]  = t[0] ^ t[1];
        t[8]  = v[0] ^ v[3];
        t[9]  = v[5] ^ v[13];
        t[10] = v[7] ^ t[4];
        t[11] = t[0] ^ t[3];
        t[12] = v[14] ^ v[16];
        t[13] = v[17] ^ v[1];
        t[14] = v[17] ^ v[12];
        t[15] = v[4] ^ v[9];
        t[16] = v[7] ^ v[11];
        t[17] = v[8] ^ t[2];
        t[18] = v[13] ^ t[5];
        t[19] = t[2] ^ t[3];
        t[20] = t[4] ^ t[6];
        t[22] = t[2] ^ t[7];
        t[23] = t[7] ^ t[8];
        t[24] = t[5] ^ t[7];
        t[25] = t[6] ^ t[10];
        t[26] = t[9] ^ t[11];
        t[27] = t[10] ^ t[18];
        t[28] = t[11] ^ t[25];
        t[29] = t[15] ^ t[20];
        o[0]  = t[9] ^ t[16];
        o[1]  = t[14] ^ t[23];
        o[2]  = t[19] ^ t[24];
        o[3]  = t[23] ^ t[27];
        o[4]  = t[12] ^ t[22];
        o[5]  = t[17] ^ t[28];
        o[6]  = t[26] ^ t[29];
        o[7]  = t[13] ^ t[22];
        return o;
    endfunction

    // constant only lands on share 0
    for (genvar s = 0; s < `SBOX_SHARES; s++) begin : g_share
        assign y[s] = (dir == sbox_pkg::SBOX_DEC) ? inv_out(x[s]) : fwd_out(x[s], s == 0);
    end

endmodule

// ==== sbox_inv_mid.sv ====
// four-stage masked nonlinear middle layer built from dom_and gates
`timescale 1ns/1ns
`include "sbox_settings.svh"

module sbox_inv_mid (
    input  logic                       g_clk,
    input  logic                       advance,
    input  logic [`SBOX_RAND_BITS-1:0] rng,
    input  sbox_pkg::top_vec_t         x,
    output sbox_pkg::mid_vec_t         y
);

    localparam int RPA = `SBOX_RAND_PER_AND;

    // bit-major views, one share_bit_t per signal bit
    sbox_pkg::share_bit_t [`SBOX_TOP_BITS-1:0]  xs, xs_d1, xs_d2, xs_d3;
    sbox_pkg::share_bit_t [`SBOX_AND_GATES-1:0] and_a, and_b, and_y;

    sbox_pkg::share_bit_t t1, t2, t4, t6, t7, t9, t11, t12, t14;
    sbox_pkg::share_bit_t t0, t3, t5, t8, t10, t13, t15, t16, t17, t18, t19;
    sbox_pkg::share_bit_t t20, t21, t22, t23, t24, t27, t25, t31, t34;
    sbox_pkg::share_bit_t t21_q, t23_q, t24_q, t27_q, t26, t28, t33, t36;
    sbox_pkg::share_bit_t t29, t30, t32, t35, t21_qq, t23_qq, t33_q, t36_q;
    sbox_pkg::share_bit_t t37, t38, t39, t40, t41, t42, t43, t44, t45;

    for (genvar i = 0; i < `SBOX_TOP_BITS; i++) begin : g_in_bit
        for (genvar s = 0; s < `SBOX_SHARES; s++) begin : g_in_share
            assign xs[i][s] = x[s][i];
        end
    end

    for (genvar i = 0; i < `SBOX_MID_BITS; i++) begin : g_out_bit
        for (genvar s = 0; s < `SBOX_SHARES; s++) begin : g_out_share
            assign y[s][i] = and_y[16 + i][s];
        end
    end

    for (genvar g = 0; g < `SBOX_AND_GATES; g++) begin : g_and
        dom_and #(
            .SHARES(`SBOX_SHARES)
        ) u_and (
            .g_clk  (g_clk),
            .advance(advance),
            .rng    (rng[g*RPA +: RPA]),
            .a      (and_a[g]),
            .b      (and_b[g]),
            .y      (and_y[g])
        );
    end

    // stage 1, gates 0..8 on the raw input bits
    assign and_a[8:0] = {xs[2], xs[4], xs[1], xs[15], xs[16], xs[3], xs[14], xs[17], xs[9]};
    assign and_b[8:0] = {xs[8], xs[20], xs[11], xs[13], xs[7], xs[12], xs[0], xs[6], xs[5]};
    assign {t14, t12, t11, t9, t7, t6, t4, t2, t1} = and_y[8:0];

    // stage 2, gates 9..11
    assign t0  = xs_d1[3] ^ xs_d1[12];
    assign t3  = xs_d1[10] ^ t1;
    assign t5  = t4 ^ t1;
    assign t8  = t0 ^ t6;
    assign t10 = t9 ^ t6;
    assign t13 = t12 ^ t11;
    assign t15 = t14 ^ t11;
    assign t16 = t3 ^ t2;
    assign t17 = t5 ^ xs_d1[18];
    assign t18 = t8 ^ t7;
    assign t19 = t10 ^ t15;
    assign t20 = t16 ^ t13;
    assign t21 = t17 ^ t15;
    assign t22 = t18 ^ t13;
    assign t23 = t19 ^ xs_d1[19];
    assign t24 = t22 ^ t23;
    assign t27 = t20 ^ t21;
    assign and_a[11:9] = {t21, t20, t22};
    assign and_b[11:9] = {t22, t23, t20};
    assign {t34, t31, t25} = and_y[11:9];

    // stage 3, gates 12..15
    assign t26 = t21_q ^ t25;
    assign t28 = t23_q ^ t25;
    assign t33 = t27_q ^ t25;
    assign t36 = t24_q ^ t25;
    assign and_a[15:12] = {t24_q, t27_q, t26, t28};
    assign and_b[15:12] = {t34, t31, t24_q, t27_q};
    assign {t35, t32, t30, t29} = and_y[15:12];

    // stage 4, eighteen output gates
    assign t37 = t21_qq ^ t29;
    assign t38 = t32 ^ t33_q;
    assign t39 = t23_qq ^ t30;
    assign t40 = t35 ^ t36_q;
    assign t41 = t38 ^ t40;
    assign t42 = t37 ^ t39;
    assign t43 = t37 ^ t38;
    assign t44 = t39 ^ t40;
    assign t45 = t42 ^ t41;
    assign and_a[33:16] = {2{t43, t39, t40, t44, t41, t45, t42, t37, t38}};
    assign and_b[33:16] = {xs_d3[12], xs_d3[0], xs_d3[6], xs_d3[5], xs_d3[2], xs_d3[4],
                           xs_d3[1], xs_d3[15], xs_d3[16], xs_d3[3], xs_d3[14], xs_d3[17],
                           xs_d3[9], xs_d3[8], xs_d3[20], xs_d3[11], xs_d3[13], xs_d3[7]};

    // linear terms and input bits kept in step with the gates
    always_ff @(posedge g_clk) begin
        if (advance) begin
            xs_d1  <= xs;
            xs_d2  <= xs_d1;
            xs_d3  <= xs_d2;
            t21_q  <= t21;
            t23_q  <= t23;
            t24_q  <= t24;
            t27_q  <= t27;
            t21_qq <= t21_q;
            t23_qq <= t23_q;
            t33_q  <= t33;
            t36_q  <= t36;
        end
    end

endmodule

// ==== sbox_pipe_ctrl.sv ====
// per-stage valid and direction tracking, stall and handshake outputs
`timescale 1ns/1ns
`include "sbox_settings.svh"

module sbox_pipe_ctrl (
    input  logic                g_clk,
    input  logic                reset,
    input  logic                in_valid,
    input  sbox_pkg::sbox_dir_t in_dir,
    output logic                in_ready,
    output logic                out_valid,
    input  logic                out_ready,
    output sbox_pkg::sbox_dir_t out_dir,
    output logic                advance
);

    logic [`SBOX_STAGES-1:0]                stage_valid;
    sbox_pkg::sbox_dir_t [`SBOX_STAGES-1:0] stage_dir;
    logic                                   stall;

    // whole pipe moves together, only a blocked last stage holds it
    assign stall     = stage_valid[`SBOX_STAGES-1] & ~out_ready;
    assign advance   = ~stall;
    assign in_ready  = ~stall;
    assign out_valid = stage_valid[`SBOX_STAGES-1];
    assign out_dir   = stage_dir[`SBOX_STAGES-1];

    always_ff @(posedge g_clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[`SBOX_STAGES-2:0], in_valid};
        end
    end

    // direction rides with each item
    always_ff @(posedge g_clk) begin
        if (advance) begin
            stage_dir[0] <= in_dir;
            for (int k = 1; k < `SBOX_STAGES; k++) begin
                stage_dir[k] <= stage_dir[k-1];
            end
        end
    end

    a_stall_hold: assert property (@(posedge g_clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_dir));

    a_ready_idle: assert property (@(posedge g_clk) disable iff (reset)
        !out_valid |-> in_ready);

endmodule

// ==== masked_aes_sbox.sv ====
// top level of the masked forward/inverse AES S-box pipeline
`timescale 1ns/1ns
`include "sbox_settings.svh"

module masked_aes_sbox (
    input  logic                       g_clk,
    input  logic                       reset,
    input  sbox_pkg::sbox_req_t        req,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [`SBOX_RAND_BITS-1:0] rng,
    output sbox_pkg::sbox_rsp_t        rsp,
    output logic                       out_valid,
    input  logic                       out_ready
);

    logic                advance;
    sbox_pkg::sbox_dir_t out_dir;
    sbox_pkg::top_vec_t  top_vec;
    sbox_pkg::mid_vec_t  mid_vec;

    sbox_pipe_ctrl u_ctrl (
        .g_clk    (g_clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_dir   (req.dir),
        .in_ready (in_ready),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_dir  (out_dir),
        .advance  (advance)
    );

    // input layer follows the incoming item's direction
    sbox_in_layer u_in (
        .dir(req.dir),
        .x  (req.data),
        .y  (top_vec)
    );

    sbox_inv_mid u_mid (
        .g_clk  (g_clk),
        .advance(advance),
        .rng    (rng),
        .x      (top_vec),
        .y      (mid_vec)
    );

    // output layer follows the direction of the item in the last stage
    sbox_out_layer u_out (
        .dir(out_dir),
        .x  (mid_vec),
        .y  (rsp.data)
    );

endmodule

// ==== tb_clk_gen.sv ====
// testbench clock and synchronous reset source
`timescale 1ns/1ns

module tb_clk_gen (
    output logic g_clk,
    output logic reset
);

    // 20 ns period
    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;
    end

    // reset high for the first 4 rising edges, released just after the edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge g_clk);
        #2 reset = 1'b0;
    end

endmodule

// ==== masked_aes_sbox_tb.sv ====
// masked S-box testbench with stimulus, reference S-box model, scoreboard and assertions
`timescale 1ns/1ns
`include "sbox_settings.svh"

module masked_aes_sbox_tb;

    // three runs of 256 items, worst case about five cycles per item plus slack
    localparam int ITEMS      = 3 * 256;
    localparam int MAX_CYCLES = 5 * ITEMS + 160;

    logic                       g_clk;
    logic                       reset;
    sbox_pkg::sbox_req_t        req;
    logic                       in_valid;
    logic                       in_ready;
    logic [`SBOX_RAND_BITS-1:0] rng;
    sbox_pkg::sbox_rsp_t        rsp;
    logic                       out_valid;
    logic                       out_ready;

    logic [31:0] lfsr_state = 32'h4996_cb16;
    logic [7:0]  fwd_tbl [256];
    logic [7:0]  inv_tbl [256];
    logic [7:0]  exp_q [$];
    logic [7:0]  exp_head = 8'h00;
    logic [7:0]  rsp_byte;
    sbox_pkg::sbox_rsp_t rsp_prev;
    int          exp_cnt = 0;
    int          n_acc = 0;
    int          n_rsp = 0;
    int          cycles = 0;
    int          err_data = 0;
    int          err_timing = 0;
    int          err_hold = 0;
    int          err_other = 0;

    tb_clk_gen u_clk (
        .g_clk(g_clk),
        .reset(reset)
    );

    masked_aes_sbox dut0 (
        .g_clk    (g_clk),
        .reset    (reset),
        .req      (req),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .rng      (rng),
        .rsp      (rsp),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw(input int n, output logic [127:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[126:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) p ^= x;
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // a^254 is the field inverse, and maps 0 to 0
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] r;
        r = 8'h01;
        for (int i = 0; i < 254; i++) begin
            r = gf_mul(r, a);
        end
        return r;
    endfunction

    function automatic logic [7:0] sbox_fwd(input logic [7:0] b);
        logic [7:0] v;
        v = gf_inv(b);
        return v ^ {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^ {v[4:0], v[7:5]} ^ {v[3:0], v[7:4]}
               ^ 8'h63;
    endfunction

    function automatic logic [7:0] xor_shares(input sbox_pkg::masked_byte_t v);
        logic [7:0] acc;
        acc = 8'h00;
        for (int s = 0; s < `SBOX_SHARES; s++) begin
            acc ^= v[s];
        end
        return acc;
    endfunction

    function automatic logic [7:0] expect_byte(input sbox_pkg::sbox_req_t r);
        return (r.dir == sbox_pkg::SBOX_DEC) ? inv_tbl[xor_shares(r.data)]
                                              : fwd_tbl[xor_shares(r.data)];
    endfunction

    assign rsp_byte = xor_shares(rsp.data);

    // random masks on all but the last share, last share fixes the value
    task automatic load_item(input logic [7:0] b, input sbox_pkg::sbox_dir_t d);
        logic [127:0] m;
        logic [7:0]   acc;
        acc = b;
        for (int s = 0; s < `SBOX_SHARES - 1; s++) begin
            draw(8, m);
            req.data[s] = m[7:0];
            acc ^= m[7:0];
        end
        req.data[`SBOX_SHARES-1] = acc;
        req.dir = d;
        in_valid = 1'b1;
    endtask

    // mode 0 forward, 1 inverse, 2 alternating with random gaps and back-pressure
    task automatic run_items(input int count, input int mode);
        logic [127:0] r;
        int           sent;
        logic         take;
        logic         go;
        sent = 0;
        take = 1'b0;
        while (sent < count) begin
            @(posedge g_clk);
            #2;
            if (take) sent++;
            draw(2, r);
            out_ready = (mode == 2) ? (r[1:0] != 2'b00) : 1'b1;
            draw(1, r);
            go = (mode != 2) || r[0];
            if (!in_valid || take) begin
                if (sent < count && go) begin
                    load_item(sent[7:0], (mode == 1 || (mode == 2 && sent[0]))
                              ? sbox_pkg::SBOX_DEC : sbox_pkg::SBOX_ENC);
                end else begin
                    in_valid = 1'b0;
                end
            end
            draw(`SBOX_RAND_BITS, r);
            rng = r[`SBOX_RAND_BITS-1:0];
            @(negedge g_clk);
            take = in_valid && in_ready;
        end
    endtask

    // expected bytes in request order
    always @(posedge g_clk) begin
        if (reset) begin
            exp_q.delete();
        end else begin
            if (out_valid && out_ready) begin
                n_rsp++;
                if (exp_q.size() > 0) void'(exp_q.pop_front());
            end
            if (in_valid && in_ready) begin
                n_acc++;
                exp_q.push_back(expect_byte(req));
            end
        end
        exp_cnt = exp_q.size();
        exp_head = (exp_q.size() > 0) ? exp_q[0] : 8'h00;
    end

    // response one edge back, for the hold report
    always @(posedge g_clk) begin
        rsp_prev <= rsp;
    end

    always @(posedge g_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    a_reset_idle: assert property (@(posedge g_clk) $fell(reset) |-> !out_valid && in_ready)
        else begin
            err_other++;
            $display("pipeline not idle right after reset");
        end

    a_no_early: assert property (@(posedge g_clk) disable iff (reset)
        out_valid |-> exp_cnt != 0)
        else begin
            err_other++;
            $display("response appeared with no request outstanding");
        end

    a_data: assert property (@(posedge g_clk) disable iff (reset)
        out_valid && out_ready && exp_cnt != 0 |-> rsp_byte == exp_head)
        else begin
            err_data++;
            $display("error rsp.data expected %h got %h", $sampled(exp_head), $sampled(rsp_byte));
        end

    // four unstalled edges from acceptance to the response transfer
    a_latency: assert property (@(posedge g_clk) disable iff (reset)
        (in_valid && in_ready) ##1 in_ready [*3] |=> out_valid)
        else begin
            err_timing++;
            $display("error out_valid expected 1 got %h", $sampled(out_valid));
        end

    a_hold_valid: assert property (@(posedge g_clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid)
        else begin
            err_hold++;
            $display("error out_valid expected 1 got %h", $sampled(out_valid));
        end

    a_hold_data: assert property (@(posedge g_clk) disable iff (reset)
        out_valid && !out_ready |=> $stable(rsp))
        else begin
            err_hold++;
            $display("error rsp expected %h got %h", $sampled(rsp_prev), $sampled(rsp));
        end

    a_ready_stall: assert property (@(posedge g_clk) disable iff (reset)
        in_ready == !(out_valid && !out_ready))
        else begin
            err_hold++;
            $display("error in_ready expected %h got %h",
                     !$sampled(out_valid && !out_ready), $sampled(in_ready));
        end

    initial begin
        req = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        rng = '0;
        for (int i = 0; i < 256; i++) begin
            fwd_tbl[i] = sbox_fwd(i[7:0]);
        end
        for (int y = 0; y < 256; y++) begin
            for (int x = 0; x < 256; x++) begin
                if (fwd_tbl[x] == y[7:0]) inv_tbl[y] = x[7:0];
            end
        end
        if (fwd_tbl[8'h00] != 8'h63 || fwd_tbl[8'h53] != 8'hed) begin
            err_other++;
            $display("reference S-box model gives wrong known values");
        end
        @(negedge reset);
        repeat (3) begin
            @(posedge g_clk);
            #2;
            out_ready = 1'b1;
        end
        run_items(256, 0);
        run_items(256, 1);
        run_items(256, 2);
        @(posedge g_clk);
        #2;
        in_valid = 1'b0;
        out_ready = 1'b1;
        while (exp_cnt != 0) @(posedge g_clk);
        repeat (4) @(posedge g_clk);
        if (n_acc != ITEMS || n_rsp != ITEMS) begin
            err_other++;
            $display("accepted %0d requests and saw %0d responses, wanted %0d each",
                     n_acc, n_rsp, ITEMS);
        end
        $display("errors: data %0d, latency %0d, stall %0d, other %0d",
                 err_data, err_timing, err_hold, err_other);
        if (err_data + err_timing + err_hold + err_other == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
sbox_pkg.sv
dom_and.sv
sbox_in_layer.sv
sbox_out_layer.sv
sbox_inv_mid.sv
sbox_pipe_ctrl.sv
masked_aes_sbox.sv
tb_clk_gen.sv
masked_aes_sbox_tb.sv
